//--- vlog.f
+incdir+include
verilog/corebus_pkg.sv
verilog/corebus_router.sv
verilog/corebus_memory_bank.sv
verilog/corebus_response_arbiter.sv
verilog/corebus_protocol_checker.sv
verilog/corebus_top.sv
sim/tb_corebus.sv

//--- sim/tb_corebus.sv
`timescale 1ns/1ps
// directed testbench for the core bus subsystem, responses matched by id
// tests only read back words that an earlier test has written
`include "corebus_params.svh"

module tb_corebus;
  import corebus_pkg::*;

  localparam int TIMEOUT_CYCLES = 3000;  // about 5x the worst case under back-pressure
  localparam int WORDS          = `CB_BANKS * `CB_BANK_WORDS;
  localparam int IDS            = 2 ** `CB_ID_WIDTH;
  localparam int BYTES          = `CB_DATA_WIDTH / 8;

  logic                clk = 1'b0;
  logic                i_rst_n;
  logic                i_mcmd_valid;
  corebus_command_t    i_mcmd;
  logic                o_scmd_accept;
  logic                i_mdata_valid;
  corebus_write_data_t i_mdata;
  logic                o_sdata_accept;
  logic                o_sresp_valid;
  corebus_response_t   o_sresp;
  logic                i_mresp_accept;

  logic [`CB_DATA_WIDTH-1:0] ref_mem [WORDS];
  logic [`CB_DATA_WIDTH-1:0] exp_data [IDS][`CB_MAX_LENGTH];
  corebus_opcode_e           exp_op [IDS];
  int                        exp_beats [IDS] = '{default: 0};
  int                        got_beats [IDS] = '{default: 0};
  int                        round_ids [$];
  logic [31:0]               lfsr_state = 32'h3a0e;
  logic                      bp_on = 1'b0;     // random response back-pressure
  logic                      in_burst = 1'b0;
  int                        burst_id = 0;
  int                        done_count = 0;   // bursts finished in this round
  int                        error_count = 0;
  int                        check_count = 0;
  int                        tests_run = 0;
  int                        cycles = 0;

  corebus_top uut (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_mcmd_valid   (i_mcmd_valid),
    .i_mcmd         (i_mcmd),
    .o_scmd_accept  (o_scmd_accept),
    .i_mdata_valid  (i_mdata_valid),
    .i_mdata        (i_mdata),
    .o_sdata_accept (o_sdata_accept),
    .o_sresp_valid  (o_sresp_valid),
    .o_sresp        (o_sresp),
    .i_mresp_accept (i_mresp_accept)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: no finish after %0d cycles", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  always @(posedge clk) begin
    if (i_rst_n && o_sresp_valid && i_mresp_accept) record_beat(o_sresp);
  end

  // taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  function automatic int burst_len(input logic [`CB_LENGTH_WIDTH-1:0] len);
    return (len == 0) ? `CB_MAX_LENGTH : int'(len);
  endfunction

  // burst words wrap inside the bank that owns the base address
  function automatic int word_index(input logic [`CB_ADDR_WIDTH-1:0] addr, input int k);
    return (addr / `CB_BANK_WORDS) * `CB_BANK_WORDS + (addr % `CB_BANK_WORDS + k) % `CB_BANK_WORDS;
  endfunction

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, actual, expected);
      error_count++;
    end
  endtask

  task automatic record_beat(input corebus_response_t r);
    int k;
    k = got_beats[r.id];
    if (in_burst && (r.id != burst_id)) begin
      $display("error at %0t: id %0d beat inside the burst of id %0d", $time, r.id, burst_id);
      error_count++;
    end
    if (k >= exp_beats[r.id]) begin
      $display("error at %0t: unexpected response beat for id %0d", $time, r.id);
      error_count++;
    end else begin
      check_equal(r.opcode, exp_op[r.id], "response opcode");
      check_equal(r.data, exp_data[r.id][k], "response data");
      check_equal(r.last, (k + 1) == exp_beats[r.id], "response last");
    end
    got_beats[r.id] = k + 1;
    in_burst        = !r.last;
    burst_id        = r.id;
    if (r.last) done_count++;
  endtask

  task automatic next_cycle();
    @(negedge clk);
    i_mresp_accept = bp_on ? lfsr_bit() : 1'b1;
  endtask

  task automatic send_command(input corebus_opcode_e op, input logic [`CB_ID_WIDTH-1:0] id,
                              input logic [`CB_ADDR_WIDTH-1:0] addr,
                              input logic [`CB_LENGTH_WIDTH-1:0] len);
    logic taken;
    i_mcmd_valid = 1'b1;
    i_mcmd       = '{opcode: op, id: id, address: addr, length: len};
    taken        = 1'b0;
    while (!taken) begin
      @(posedge clk);
      taken = o_scmd_accept;
      next_cycle();
    end
    i_mcmd_valid = 1'b0;
  endtask

  task automatic send_write_data(input logic [`CB_ADDR_WIDTH-1:0] addr,
                                 input logic [`CB_LENGTH_WIDTH-1:0] len, input logic full_be);
    logic [`CB_DATA_WIDTH-1:0] word;
    logic [BYTES-1:0]          be;
    logic                      taken;
    int                        idx;
    for (int k = 0; k < burst_len(len); k++) begin
      word = rand_bits(`CB_DATA_WIDTH);
      be   = full_be ? '1 : BYTES'(rand_bits(BYTES));
      idx  = word_index(addr, k);
      for (int b = 0; b < BYTES; b++) begin
        if (be[b]) ref_mem[idx][8*b +: 8] = word[8*b +: 8];
      end
      i_mdata_valid = 1'b1;
      i_mdata       = '{data: word, byte_enable: be, last: (k + 1) == burst_len(len)};
      taken         = 1'b0;
      while (!taken) begin
        @(posedge clk);
        taken = o_sdata_accept;
        next_cycle();
      end
    end
    i_mdata_valid = 1'b0;
  endtask

  task automatic expect_write(input logic [`CB_ID_WIDTH-1:0] id);
    exp_op[id]      = CB_WRITE;
    exp_beats[id]   = 1;
    exp_data[id][0] = '0;
    round_ids.push_back(id);
  endtask

  task automatic read_burst(input logic [`CB_ID_WIDTH-1:0] id,
                            input logic [`CB_ADDR_WIDTH-1:0] addr,
                            input logic [`CB_LENGTH_WIDTH-1:0] len);
    exp_op[id]    = CB_READ;
    exp_beats[id] = burst_len(len);
    for (int k = 0; k < burst_len(len); k++) exp_data[id][k] = ref_mem[word_index(addr, k)];
    round_ids.push_back(id);
    send_command(CB_READ, id, addr, len);
  endtask

  task automatic write_burst(input logic [`CB_ID_WIDTH-1:0] id,
                             input logic [`CB_ADDR_WIDTH-1:0] addr,
                             input logic [`CB_LENGTH_WIDTH-1:0] len, input logic full_be);
    expect_write(id);
    send_command(CB_WRITE, id, addr, len);
    send_write_data(addr, len, full_be);
  endtask

  // waits for n finished bursts, then checks every id of the round got all its beats
  task automatic finish_round(input int n);
    while (done_count < n) next_cycle();
    foreach (round_ids[i]) begin
      check_equal(got_beats[round_ids[i]], exp_beats[round_ids[i]], "beat count");
      exp_beats[round_ids[i]] = 0;
      got_beats[round_ids[i]] = 0;
    end
    round_ids.delete();
    done_count = 0;
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    $display("%s: %0d errors", name, error_count - errs_before);
  endtask

  task automatic test_single_write_read();
    int errs;
    errs = error_count;
    write_burst(4'd1, 8'h05, 2'd1, 1'b1);
    finish_round(1);
    read_burst(4'd2, 8'h05, 2'd1);
    finish_round(1);
    report_test("single write and read", errs);
  endtask

  task automatic test_byte_enable_wrap();
    int errs;
    errs = error_count;
    write_burst(4'd1, 8'h3e, 2'd0, 1'b1);  // fill so masked bytes have known values
    finish_round(1);
    write_burst(4'd2, 8'h3e, 2'd3, 1'b0);
    finish_round(1);
    read_burst(4'd3, 8'h3e, 2'd0);
    finish_round(1);
    report_test("byte enables and wrap", errs);
  endtask

  task automatic test_bank_decode();
    int errs;
    errs = error_count;
    for (int b = 0; b < `CB_BANKS; b++) begin
      write_burst(4'(b), 8'(b * `CB_BANK_WORDS + 10), 2'd0, 1'b1);
      finish_round(1);
    end
    for (int b = 0; b < `CB_BANKS; b++) begin
      read_burst(4'(4 + b), 8'(b * `CB_BANK_WORDS + 10), 2'd0);
      finish_round(1);
    end
    report_test("bank decode", errs);
  endtask

  task automatic test_reads_all_banks(input logic with_bp, input string name);
    int errs;
    errs  = error_count;
    bp_on = with_bp;
    for (int b = 0; b < `CB_BANKS; b++) begin
      read_burst(4'(8 + b), 8'(b * `CB_BANK_WORDS + 10), 2'(b));
    end
    finish_round(`CB_BANKS);
    bp_on = 1'b0;
    report_test(name, errs);
  endtask

  task automatic test_read_during_write();
    int errs;
    errs = error_count;
    expect_write(4'd12);
    send_command(CB_WRITE, 4'd12, 8'd20, 2'd2);
    read_burst(4'd13, 8'(2 * `CB_BANK_WORDS + 10), 2'd2);  // other bank, data still pending
    send_write_data(8'd20, 2'd2, 1'b1);
    finish_round(2);
    read_burst(4'd14, 8'd20, 2'd2);
    finish_round(1);
    report_test("read during open write", errs);
  endtask

  initial begin
    i_rst_n        = 1'b0;
    i_mcmd_valid   = 1'b0;
    i_mcmd         = '0;
    i_mdata_valid  = 1'b0;
    i_mdata        = '0;
    i_mresp_accept = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    i_rst_n = 1'b1;
    test_single_write_read();
    test_byte_enable_wrap();
    test_bank_decode();
    test_reads_all_banks(1'b0, "reads to all banks");
    test_reads_all_banks(1'b1, "reads to all banks with back-pressure");
    test_read_during_write();
    $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog/corebus_top.sv
`timescale 1ns/1ps
// core bus memory subsystem with CB_BANKS banks behind one master port
// responses from different banks may return out of order, so match by id
`include "corebus_params.svh"

module corebus_top (
  input  logic                              clk,
  input  logic                              i_rst_n,
  input  logic                              i_mcmd_valid,
  input  corebus_pkg::corebus_command_t     i_mcmd,
  output logic                              o_scmd_accept,
  input  logic                              i_mdata_valid,
  input  corebus_pkg::corebus_write_data_t  i_mdata,
  output logic                              o_sdata_accept,
  output logic                              o_sresp_valid,
  output corebus_pkg::corebus_response_t    o_sresp,
  input  logic                              i_mresp_accept
);
  import corebus_pkg::*;

  logic [`CB_BANKS-1:0]                    bank_cmd_valid;
  corebus_command_t                        bank_cmd;
  logic [`CB_BANKS-1:0]                    bank_cmd_accept;
  logic [`CB_BANKS-1:0]                    bank_data_valid;
  corebus_write_data_t                     bank_data;
  logic [`CB_BANKS-1:0]                    bank_data_accept;
  logic [`CB_BANKS-1:0]                    bank_resp_valid;
  corebus_response_t [`CB_BANKS-1:0]       bank_resp;
  logic [`CB_BANKS-1:0]                    bank_resp_accept;

  corebus_router u_router (
    .clk                (clk),
    .i_rst_n            (i_rst_n),
    .i_mcmd_valid       (i_mcmd_valid),
    .i_mcmd             (i_mcmd),
    .o_scmd_accept      (o_scmd_accept),
    .i_mdata_valid      (i_mdata_valid),
    .i_mdata            (i_mdata),
    .o_sdata_accept     (o_sdata_accept),
    .o_bank_cmd_valid   (bank_cmd_valid),
    .o_bank_cmd         (bank_cmd),
    .i_bank_cmd_accept  (bank_cmd_accept),
    .o_bank_data_valid  (bank_data_valid),
    .o_bank_data        (bank_data),
    .i_bank_data_accept (bank_data_accept)
  );

  for (genvar b = 0; b < `CB_BANKS; b++) begin : g_bank
    corebus_memory_bank u_bank (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_cmd_valid   (bank_cmd_valid[b]),
      .i_cmd         (bank_cmd),
      .o_cmd_accept  (bank_cmd_accept[b]),
      .i_data_valid  (bank_data_valid[b]),
      .i_data        (bank_data),
      .o_data_accept (bank_data_accept[b]),
      .o_resp_valid  (bank_resp_valid[b]),
      .o_resp        (bank_resp[b]),
      .i_resp_accept (bank_resp_accept[b])
    );
  end

  corebus_response_arbiter u_arbiter (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_resp_valid   (bank_resp_valid),
    .i_resp         (bank_resp),
    .o_resp_accept  (bank_resp_accept),
    .o_sresp_valid  (o_sresp_valid),
    .o_sresp        (o_sresp),
    .i_mresp_accept (i_mresp_accept)
  );

  corebus_protocol_checker u_checker (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_mcmd_valid   (i_mcmd_valid),
    .i_mcmd         (i_mcmd),
    .i_scmd_accept  (o_scmd_accept),
    .i_mdata_valid  (i_mdata_valid),
    .i_mdata        (i_mdata),
    .i_sdata_accept (o_sdata_accept),
    .i_sresp_valid  (o_sresp_valid),
    .i_sresp        (o_sresp),
    .i_mresp_accept (i_mresp_accept)
  );

endmodule

//--- verilog/corebus_protocol_checker.sv
`timescale 1ns/1ps
// protocol checks on the top-level core bus channels, drives nothing
// assumes read ids are unique while in flight
`include "corebus_params.svh"

module corebus_protocol_checker (
  input logic                              clk,
  input logic                              i_rst_n,
  input logic                              i_mcmd_valid,
  input corebus_pkg::corebus_command_t     i_mcmd,
  input logic                              i_scmd_accept,
  input logic                              i_mdata_valid,
  input corebus_pkg::corebus_write_data_t  i_mdata,
  input logic                              i_sdata_accept,
  input logic                              i_sresp_valid,
  input corebus_pkg::corebus_response_t    i_sresp,
  input logic                              i_mresp_accept
);
  import corebus_pkg::*;

  localparam int IDS         = 2 ** `CB_ID_WIDTH;
  localparam int ORDER_WIDTH = 2;

  logic                   cmd_xfer;
  logic                   data_xfer;
  logic                   resp_xfer;
  logic [ORDER_WIDTH-1:0] wr_cmd_order;    // write commands seen
  logic [ORDER_WIDTH-1:0] wr_data_order;   // write data bursts finished
  corebus_beats_t         data_beats;
  corebus_beats_t         wr_beats [2**ORDER_WIDTH];
  corebus_beats_t         rd_beats [IDS];
  corebus_beats_t         rd_count [IDS];

  assign cmd_xfer  = i_mcmd_valid && i_scmd_accept;
  assign data_xfer = i_mdata_valid && i_sdata_accept;
  assign resp_xfer = i_sresp_valid && i_mresp_accept;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_cmd_order  <= '0;
      wr_data_order <= '0;
      data_beats    <= '0;
      for (int i = 0; i < IDS; i++) rd_count[i] <= '0;
    end else begin
      if (cmd_xfer && (i_mcmd.opcode == CB_WRITE)) wr_cmd_order <= wr_cmd_order + 1'b1;
      if (data_xfer) begin
        data_beats    <= i_mdata.last ? '0 : data_beats + 1'b1;
        wr_data_order <= wr_data_order + ORDER_WIDTH'(i_mdata.last);
      end
      if (resp_xfer && (i_sresp.opcode == CB_READ)) begin
        rd_count[i_sresp.id] <= i_sresp.last ? '0 : rd_count[i_sresp.id] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_xfer && (i_mcmd.opcode == CB_WRITE)) begin
      wr_beats[wr_cmd_order] <= corebus_burst_beats(i_mcmd.length);
    end
    if (cmd_xfer && (i_mcmd.opcode == CB_READ)) begin
      rd_beats[i_mcmd.id] <= corebus_burst_beats(i_mcmd.length);
    end
  end

  a_mcmd_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_mcmd_valid && !i_scmd_accept) |=> (i_mcmd_valid && $stable(i_mcmd)));
  a_mdata_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_mdata_valid && !i_sdata_accept) |=> (i_mdata_valid && $stable(i_mdata)));
  a_sresp_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_sresp_valid && !i_mresp_accept) |=> (i_sresp_valid && $stable(i_sresp)));

  // the last data beat closes the oldest open write with its full count
  a_write_data_count: assert property (@(posedge clk) disable iff (!i_rst_n)
    (data_xfer && i_mdata.last) |->
      ((wr_cmd_order != wr_data_order) && ((data_beats + 1'b1) == wr_beats[wr_data_order])));

  a_read_resp_count: assert property (@(posedge clk) disable iff (!i_rst_n)
    (resp_xfer && (i_sresp.opcode == CB_READ)) |->
      (i_sresp.last == ((rd_count[i_sresp.id] + 1'b1) == rd_beats[i_sresp.id])));

  a_write_resp_single: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_sresp_valid && (i_sresp.opcode == CB_WRITE)) |-> i_sresp.last);

endmodule

//--- verilog/corebus_response_arbiter.sv
`timescale 1ns/1ps
// round-robin merge of bank responses onto the single response port
// a grant holds from the first presented beat until the last beat transfers
`include "corebus_params.svh"

module corebus_response_arbiter (
  input  logic                                            clk,
  input  logic                                            i_rst_n,
  input  logic [`CB_BANKS-1:0]                            i_resp_valid,
  input  corebus_pkg::corebus_response_t [`CB_BANKS-1:0]  i_resp,
  output logic [`CB_BANKS-1:0]                            o_resp_accept,
  output logic                                            o_sresp_valid,
  output corebus_pkg::corebus_response_t                  o_sresp,
  input  logic                                            i_mresp_accept
);
  import corebus_pkg::*;

  localparam int SEL_WIDTH = $clog2(`CB_BANKS);

  logic [SEL_WIDTH-1:0] rr_ptr;   // last granted bank
  logic [SEL_WIDTH-1:0] pick;
  logic [SEL_WIDTH-1:0] grant;
  logic                 pick_found;
  logic                 locked;

  // search starts one past the last grant and ends on it
  always_comb begin
    pick       = rr_ptr;
    pick_found = 1'b0;
    for (int i = 1; i <= `CB_BANKS; i++) begin
      if (!pick_found && i_resp_valid[SEL_WIDTH'(rr_ptr + i)]) begin
        pick       = SEL_WIDTH'(rr_ptr + i);
        pick_found = 1'b1;
      end
    end
  end

  assign grant         = locked ? rr_ptr : pick;
  assign o_sresp_valid = i_resp_valid[grant];
  assign o_sresp       = i_resp[grant];

  always_comb begin
    o_resp_accept        = '0;
    o_resp_accept[grant] = i_mresp_accept;
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rr_ptr <= '1;   // bank 0 wins first
      locked <= 1'b0;
    end else if (o_sresp_valid) begin
      rr_ptr <= grant;
      locked <= !(i_mresp_accept && o_sresp.last);
    end
  end

  a_grant_held_until_last: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    (o_sresp_valid && !(i_mresp_accept && o_sresp.last)) |=>
      (o_sresp_valid && (grant == $past(grant)))
  );

endmodule

//--- verilog/corebus_memory_bank.sv
`timescale 1ns/1ps
// one memory bank running a single read or write burst at a time
// bursts wrap inside the bank, and a read streams one beat per cycle
`include "corebus_params.svh"

module corebus_memory_bank (
  input  logic                              clk,
  input  logic                              i_rst_n,
  input  logic                              i_cmd_valid,
  input  corebus_pkg::corebus_command_t     i_cmd,
  output logic                              o_cmd_accept,
  input  logic                              i_data_valid,
  input  corebus_pkg::corebus_write_data_t  i_data,
  output logic                              o_data_accept,
  output logic                              o_resp_valid,
  output corebus_pkg::corebus_response_t    o_resp,
  input  logic                              i_resp_accept
);
  import corebus_pkg::*;

  localparam int OFFSET_WIDTH = $clog2(`CB_BANK_WORDS);
  localparam int BYTES        = `CB_DATA_WIDTH / 8;

  logic [`CB_DATA_WIDTH-1:0] mem [`CB_BANK_WORDS];

  corebus_bank_state_e      state;
  corebus_beats_t           beat;
  corebus_beats_t           reg_beats;
  corebus_opcode_e          reg_opcode;
  logic [`CB_ID_WIDTH-1:0]  reg_id;
  logic [OFFSET_WIDTH-1:0]  base_offset;
  logic [OFFSET_WIDTH-1:0]  word_addr;
  logic                     final_beat;

  assign o_cmd_accept  = i_cmd_valid && (state == BANK_IDLE);
  assign o_data_accept = i_data_valid && (state == BANK_WRITE);
  assign final_beat    = (beat + 1'b1) == reg_beats;
  assign word_addr     = base_offset + OFFSET_WIDTH'(beat);  // wraps inside the bank

  always_comb begin
    o_resp_valid  = (state == BANK_READ) || (state == BANK_RESP);
    o_resp.opcode = reg_opcode;
    o_resp.id     = reg_id;
    o_resp.data   = (state == BANK_READ) ? mem[word_addr] : '0;
    o_resp.last   = (state == BANK_RESP) || final_beat;
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= BANK_IDLE;
      beat  <= '0;
    end else begin
      case (state)
        BANK_IDLE: begin
          beat <= '0;
          if (o_cmd_accept) begin
            if (i_cmd.opcode == CB_WRITE) begin
              state <= BANK_WRITE;
            end else begin
              state <= BANK_READ;
            end
          end
        end
        BANK_READ: begin
          if (i_resp_accept) begin
            beat <= beat + 1'b1;
            if (final_beat) state <= BANK_IDLE;
          end
        end
        BANK_WRITE: begin
          if (o_data_accept) begin
            beat <= beat + 1'b1;
            if (i_data.last) state <= BANK_RESP;  // response valid the next cycle
          end
        end
        BANK_RESP: begin
          if (i_resp_accept) state <= BANK_IDLE;
        end
        default: state <= BANK_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (o_cmd_accept) begin
      reg_opcode  <= i_cmd.opcode;
      reg_id      <= i_cmd.id;
      base_offset <= i_cmd.address[OFFSET_WIDTH-1:0];
      reg_beats   <= corebus_burst_beats(i_cmd.length);
    end
  end

  always_ff @(posedge clk) begin
    if (o_data_accept) begin
      for (int b = 0; b < BYTES; b++) begin
        if (i_data.byte_enable[b]) mem[word_addr][8*b +: 8] <= i_data.data[8*b +: 8];
      end
    end
  end

  // master's last flag must agree with the burst length seen on the command
  a_last_on_final_beat: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    o_data_accept |-> (i_data.last == final_beat)
  );

endmodule

//--- verilog/corebus_router.sv
`timescale 1ns/1ps
// command decode and write data steering for the bank array
// only one write burst is open at a time while reads pass around it
`include "corebus_params.svh"

module corebus_router (
  input  logic                              clk,
  input  logic                              i_rst_n,
  input  logic                              i_mcmd_valid,
  input  corebus_pkg::corebus_command_t     i_mcmd,
  output logic                              o_scmd_accept,
  input  logic                              i_mdata_valid,
  input  corebus_pkg::corebus_write_data_t  i_mdata,
  output logic                              o_sdata_accept,
  output logic [`CB_BANKS-1:0]              o_bank_cmd_valid,
  output corebus_pkg::corebus_command_t     o_bank_cmd,
  input  logic [`CB_BANKS-1:0]              i_bank_cmd_accept,
  output logic [`CB_BANKS-1:0]              o_bank_data_valid,
  output corebus_pkg::corebus_write_data_t  o_bank_data,
  input  logic [`CB_BANKS-1:0]              i_bank_data_accept
);
  import corebus_pkg::*;

  localparam int SEL_WIDTH = $clog2(`CB_BANKS);

  logic [SEL_WIDTH-1:0] cmd_bank;
  logic [SEL_WIDTH-1:0] wr_bank;   // bank that owns the open write
  logic                 wr_open;
  logic                 wr_block;
  logic                 wr_cmd_xfer;
  logic                 data_xfer;

  assign cmd_bank = i_mcmd.address[`CB_ADDR_WIDTH-1 -: SEL_WIDTH];
  assign wr_block = wr_open && (i_mcmd.opcode == CB_WRITE);

  always_comb begin
    o_bank_cmd_valid           = '0;
    o_bank_cmd_valid[cmd_bank] = i_mcmd_valid && !wr_block;
  end

  assign o_bank_cmd    = i_mcmd;
  assign o_scmd_accept = i_bank_cmd_accept[cmd_bank];  // bank accept follows its valid

  always_comb begin
    o_bank_data_valid          = '0;
    o_bank_data_valid[wr_bank] = i_mdata_valid && wr_open;
  end

  assign o_bank_data    = i_mdata;
  assign o_sdata_accept = wr_open && i_bank_data_accept[wr_bank];

  assign wr_cmd_xfer = i_mcmd_valid && o_scmd_accept && (i_mcmd.opcode == CB_WRITE);
  assign data_xfer   = i_mdata_valid && o_sdata_accept;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_open <= 1'b0;
      wr_bank <= '0;
    end else if (wr_cmd_xfer) begin
      wr_open <= 1'b1;
      wr_bank <= cmd_bank;
    end else if (data_xfer && i_mdata.last) begin
      wr_open <= 1'b0;
    end
  end

  a_data_only_in_open_write: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    (i_bank_data_accept != '0) |-> wr_open && (i_bank_data_accept == (`CB_BANKS'(1) << wr_bank))
  );

endmodule

//--- verilog/corebus_pkg.sv
// channel types shared by the core bus router, banks, arbiter and checker
// a write is answered by one response beat with last set and zero data
`include "corebus_params.svh"

package corebus_pkg;

  typedef enum logic {
    CB_READ  = 1'b0,
    CB_WRITE = 1'b1
  } corebus_opcode_e;

  typedef enum logic [1:0] {
    BANK_IDLE  = 2'd0,
    BANK_READ  = 2'd1,
    BANK_WRITE = 2'd2,
    BANK_RESP  = 2'd3
  } corebus_bank_state_e;

  typedef logic [`CB_LENGTH_WIDTH:0] corebus_beats_t;  // 1 .. CB_MAX_LENGTH

  typedef struct packed {
    corebus_opcode_e              opcode;
    logic [`CB_ID_WIDTH-1:0]      id;
    logic [`CB_ADDR_WIDTH-1:0]    address;
    logic [`CB_LENGTH_WIDTH-1:0]  length;
  } corebus_command_t;

  typedef struct packed {
    logic [`CB_DATA_WIDTH-1:0]    data;
    logic [`CB_DATA_WIDTH/8-1:0]  byte_enable;
    logic                         last;
  } corebus_write_data_t;

  typedef struct packed {
    corebus_opcode_e            opcode;
    logic [`CB_ID_WIDTH-1:0]    id;
    logic [`CB_DATA_WIDTH-1:0]  data;
    logic                       last;
  } corebus_response_t;

  function automatic corebus_beats_t corebus_burst_beats(
    input logic [`CB_LENGTH_WIDTH-1:0] length
  );
    if (length == '0) begin
      return corebus_beats_t'(`CB_MAX_LENGTH);
    end
    return corebus_beats_t'(length);
  endfunction

endpackage

//--- include/corebus_params.svh
// bus widths and memory geometry for the core bus subsystem
// CB_BANKS and CB_BANK_WORDS must be powers of two
// CB_ADDR_WIDTH covers all banks, and the top bits select the bank
`ifndef COREBUS_PARAMS_SVH
`define COREBUS_PARAMS_SVH

`define CB_ADDR_WIDTH    8
`define CB_DATA_WIDTH    32
`define CB_ID_WIDTH      4
`define CB_LENGTH_WIDTH  2   // length 0 means CB_MAX_LENGTH
`define CB_MAX_LENGTH    4
`define CB_BANKS         4
`define CB_BANK_WORDS    64

`endif
